// File: rvCore.f
source/rvPkg.sv
source/instDecoder.sv
source/immGen.sv
source/aluUnit.sv
source/regFile.sv
source/pcUnit.sv
source/lsuAlign.sv
source/rvCore.sv
sim/rvCore_sva.sv
sim/rvCoreTb.sv

// File: run.sh
#!/bin/bash
# build and run the rvCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f rvCore.f --top-module rvCoreTb -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"
grep -q "Test completed successfully" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// File: sim/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    logic        clk;
    logic        rstN;
    instWord_u   inst;
    logic [63:0] readData;
    logic [63:0] pc;
    memReq_t     memReq;
    logic        halt;

    instWord_u   prog [256];
    int          progLen;
    logic [63:0] mem [64];       // 8-byte lanes indexed by addr[8:3]
    memReq_t     stores[$];      // every store seen after reset
    logic [63:0] loadAddrs[$];   // every load address seen after reset
    memReq_t     expReqs[$];
    logic [63:0] expVals[$];
    int          errors;
    int          checks;

    rvCore u_rvCore (
        .clk(clk),
        .rstN(rstN),
        .inst(inst),
        .readData(readData),
        .pc(pc),
        .memReq(memReq),
        .halt(halt)
    );

    always #50 clk = ~clk;

    function automatic instWord_u encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
        instWord_u i;
        i.rType.funct7 = f7;
        i.rType.rs2 = rs2;
        i.rType.rs1 = rs1;
        i.rType.funct3 = f3;
        i.rType.rd = rd;
        i.rType.opcode = op;
        return i;
    endfunction

    function automatic instWord_u encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
        instWord_u i;
        i.iType.imm12 = imm;
        i.iType.rs1 = rs1;
        i.iType.funct3 = f3;
        i.iType.rd = rd;
        i.iType.opcode = op;
        return i;
    endfunction

    function automatic instWord_u encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
        instWord_u i;
        i.sType.immHi = imm[11:5];
        i.sType.rs2 = rs2;
        i.sType.rs1 = rs1;
        i.sType.funct3 = f3;
        i.sType.immLo = imm[4:0];
        i.sType.opcode = opStore;
        return i;
    endfunction

    function automatic instWord_u encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
        instWord_u i;
        i = encS({imm[12], imm[10:5], imm[4:1], imm[11]}, rs2, rs1, f3);
        i.sType.opcode = opBranch;
        return i;
    endfunction

    function automatic instWord_u encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
        instWord_u i;
        i.uType.imm20 = imm;
        i.uType.rd = rd;
        i.uType.opcode = op;
        return i;
    endfunction

    function automatic instWord_u encJ(input logic [20:0] imm, input logic [4:0] rd);
        return encU({imm[20], imm[10:1], imm[11], imm[19:12]}, rd, opJal);
    endfunction

    function automatic instWord_u ebreakInst();
        return encI(12'd1, 5'd0, 3'b000, 5'd0, opSystem);
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // memory fill mixing the whole lane index
    function automatic logic [63:0] patternAt(input logic [5:0] idx);
        return 64'ha5a5_0000_0000_0000 ^ ({58'b0, idx} * 64'h9e37_79b9_7f4a_7c15);
    endfunction

    // RV64I arithmetic reference
    function automatic logic [63:0] refAlu(input logic [6:0] op, input logic [2:0] f3,
                                           input logic alt, input logic [63:0] a,
                                           input logic [63:0] b);
        logic        isReg;
        logic [31:0] w;
        isReg = (op == opReg) || (op == opRegW);
        if (op == opRegW || op == opImmW) begin
            case (f3)
                3'd0:    w = (alt && isReg) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                3'd1:    w = a[31:0] << b[4:0];
                default: w = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
            endcase
            return sext32(w);
        end
        case (f3)
            3'd0:    return (alt && isReg) ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'b0, $signed(a) < $signed(b)};
            3'd3:    return {63'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit opValid(input logic [6:0] op, input logic [2:0] f3,
                                   input logic alt);
        if ((op == opRegW || op == opImmW) && !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
            return 1'b0;
        if (!alt || f3 == 3'd5)
            return 1'b1;
        return (f3 == 3'd0) && (op == opReg || op == opRegW);
    endfunction

    function automatic bit branchTaken(input logic [2:0] f3, input logic [63:0] a,
                                       input logic [63:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [63:0] extendLoad(input logic [63:0] v, input int bytes,
                                               input bit sgn);
        case (bytes)
            1:       return sgn ? {{56{v[7]}}, v[7:0]} : {56'b0, v[7:0]};
            2:       return sgn ? {{48{v[15]}}, v[15:0]} : {48'b0, v[15:0]};
            4:       return sgn ? sext32(v[31:0]) : {32'b0, v[31:0]};
            default: return v;
        endcase
    endfunction

    // instruction for the pc or a nop outside the program window
    always @(negedge clk) begin
        if ($isunknown(pc) || pc < resetPc || pc >= resetPc + 64'd1024)
            inst <= encI(12'd0, 5'd0, 3'b000, 5'd0, opImm);
        else
            inst <= prog[pc[9:2]];
    end

    assign readData = mem[memReq.addr[8:3]];

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 64; i++) begin
                mem[i] <= patternAt(6'(i));
            end
        end else begin
            if (memReq.readEn)
                loadAddrs.push_back(memReq.addr);
            if (memReq.writeMask != 8'h00) begin
                stores.push_back(memReq);
                for (int b = 0; b < 8; b++) begin
                    if (memReq.writeMask[b])
                        mem[memReq.addr[8:3]][b*8 +: 8] <= memReq.writeData[b*8 +: 8];
                end
            end
        end
    end

    task automatic emit(input instWord_u i);
        prog[progLen] = i;
        progLen++;
    endtask

    task automatic clearProg();
        foreach (prog[i]) prog[i] = ebreakInst();
        progLen = 0;
        stores.delete();
        loadAddrs.delete();
        expReqs.delete();
        expVals.delete();
    endtask

    // lui + addi pair that leaves v in rd
    task automatic loadImm(input logic [4:0] rd, input logic [31:0] val,
                           output logic [63:0] v);
        logic [31:0] up;
        up = (val + 32'h800) >> 12;
        emit(encU(up[19:0], rd, opLui));
        emit(encI(val[11:0], rd, 3'b000, rd, opImm));
        v = sext32({up[19:0], 12'h000}) + sext12(val[11:0]);
    endtask

    task automatic failTimeout(input string what);
        $display("timeout: %s never finished", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic startProg();
        @(negedge clk);
        rstN = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic waitHalt(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!halt && n < 500);
        if (!halt)
            failTimeout(what);
    endtask

    task automatic waitPc(input logic [63:0] target, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (pc != target && n < 200);
        if (pc != target)
            failTimeout(what);
    endtask

    task automatic checkWord(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkReq(input memReq_t got, input memReq_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR memReq: got addr=%h data=%h mask=%h readEn=%h", got.addr,
                     got.writeData, got.writeMask, got.readEn);
            $display("ERROR memReq: expected addr=%h data=%h mask=%h readEn=%h", exp.addr,
                     exp.writeData, exp.writeMask, exp.readEn);
        end
    endtask

    task automatic checkPc(input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR pc: got %h expected %h", got, exp);
        end
    endtask

    task automatic checkStoreResults(input string what, input int first);
        if (stores.size() != first + expVals.size()) begin
            errors++;
            $display("%s: saw %0d stores but expected %0d", what, stores.size(),
                     first + expVals.size());
        end else begin
            foreach (expVals[k]) checkWord("sd data", stores[first + k].writeData, expVals[k]);
        end
    endtask

    task automatic aluTest();
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] rnd;
        logic [11:0] imm12;
        logic [6:0]  ops [4];
        logic        word;
        int          k;
        clearProg();
        loadImm(5'd1, $urandom, a);
        loadImm(5'd2, $urandom, b);
        ops = '{opReg, opRegW, opImm, opImmW};
        k = 0;
        foreach (ops[o]) begin
            for (int f = 0; f < 8; f++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (opValid(ops[o], 3'(f), alt[0])) begin
                        word = (ops[o] == opRegW) || (ops[o] == opImmW);
                        rnd = $urandom;
                        if (ops[o] == opReg || ops[o] == opRegW) begin
                            emit(encR({1'b0, alt[0], 5'b0}, 5'd2, 5'd1, 3'(f), 5'd5, ops[o]));
                            expVals.push_back(refAlu(ops[o], 3'(f), alt[0], a, b));
                        end else begin
                            if (f == 1 || f == 5)
                                imm12 = {1'b0, alt[0], 4'b0, ~word & rnd[5], rnd[4:0]};
                            else
                                imm12 = rnd[11:0];
                            emit(encI(imm12, 5'd1, 3'(f), 5'd5, ops[o]));
                            expVals.push_back(refAlu(ops[o], 3'(f), alt[0], a, sext12(imm12)));
                        end
                        emit(encS(12'(k * 8), 5'd5, 5'd0, 3'b011));
                        k++;
                    end
                end
            end
        end
        startProg();
        waitHalt("alu program");
        checkStoreResults("alu", 0);
    endtask

    task automatic memTest();
        logic [63:0] v;
        logic [63:0] w;
        memReq_t     r;
        logic [63:0] expAddrs[$];
        int          bytes;
        int          k;
        clearProg();
        loadImm(5'd2, $urandom, v);
        for (int s = 0; s < 4; s++) begin
            bytes = 1 << s;
            for (int o = 0; o + bytes <= 8; o++) begin
                emit(encS(12'h1c0 + 12'(o), 5'd2, 5'd0, 3'(s)));
                r.addr = 64'h1c0 + 64'(o);
                r.writeData = v << (8 * o);
                r.writeMask = 8'((1 << bytes) - 1) << o;
                r.readEn = 1'b0;
                expReqs.push_back(r);
            end
        end
        w = patternAt(6'd48);  // lane at 0x180
        k = 0;
        for (int s = 0; s < 4; s++) begin
            bytes = 1 << s;
            for (int sgn = 0; sgn < 2; sgn++) begin
                for (int o = 0; o + bytes <= 8 && (s < 3 || sgn == 1); o++) begin
                    emit(encI(12'h180 + 12'(o), 5'd0, {~sgn[0], 2'(s)}, 5'd5, opLoad));
                    emit(encS(12'(k * 8), 5'd5, 5'd0, 3'b011));
                    expAddrs.push_back(64'h180 + 64'(o));
                    expVals.push_back(extendLoad(w >> (8 * o), bytes, sgn[0]));
                    k++;
                end
            end
        end
        startProg();
        waitHalt("load/store program");
        for (int i = 0; i < expReqs.size() && i < stores.size(); i++) begin
            checkReq(stores[i], expReqs[i]);
        end
        checkStoreResults("load", expReqs.size());
        if (loadAddrs.size() != expAddrs.size()) begin
            errors++;
            $display("load: saw %0d reads but expected %0d", loadAddrs.size(),
                     expAddrs.size());
        end else begin
            foreach (expAddrs[i]) begin
                checkWord("memReq.addr", loadAddrs[i], expAddrs[i]);
            end
        end
    endtask

    task automatic branchTest();
        logic [2:0]  f3s [6];
        logic [11:0] pa [3];
        logic [11:0] pb [3];
        logic [63:0] exp;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        pa = '{12'hfff, 12'h001, 12'h003};
        pb = '{12'h001, 12'hfff, 12'h003};
        foreach (f3s[f]) begin
            foreach (pa[p]) begin
                clearProg();
                emit(encI(pa[p], 5'd0, 3'b000, 5'd1, opImm));
                emit(encI(pb[p], 5'd0, 3'b000, 5'd2, opImm));
                emit(encB(13'd16, 5'd2, 5'd1, f3s[f]));
                if (branchTaken(f3s[f], sext12(pa[p]), sext12(pb[p])))
                    exp = resetPc + 64'd24;
                else
                    exp = resetPc + 64'd12;
                startProg();
                waitPc(resetPc + 64'd8, "branch");
                @(negedge clk);
                checkPc(pc, exp);
                waitHalt("branch program");
            end
        end
    endtask

    task automatic jumpTest();
        clearProg();
        emit(encU(20'habcde, 5'd1, opLui));
        emit(encU(20'h12345, 5'd2, opAuipc));
        emit(encJ(21'd12, 5'd3));                        // to index 5
        emit(ebreakInst());
        emit(ebreakInst());
        emit(encU(20'h0, 5'd4, opAuipc));
        emit(encI(12'd13, 5'd4, 3'b000, 5'd5, opJalr));  // odd target landing on index 8
        emit(ebreakInst());
        emit(encS(12'd0, 5'd1, 5'd0, 3'b011));
        emit(encS(12'd8, 5'd2, 5'd0, 3'b011));
        emit(encS(12'd16, 5'd3, 5'd0, 3'b011));
        emit(encS(12'd24, 5'd5, 5'd0, 3'b011));
        expVals = '{64'hffff_ffff_abcd_e000, resetPc + 64'h1234_5004, resetPc + 64'd12,
                    resetPc + 64'd28};
        startProg();
        waitPc(resetPc + 64'd8, "jal");
        @(negedge clk);
        checkPc(pc, resetPc + 64'd20);
        @(negedge clk);
        @(negedge clk);
        checkPc(pc, resetPc + 64'd32);
        waitHalt("jump program");
        checkStoreResults("jump", 0);
    endtask

    task automatic zeroRegTest();
        clearProg();
        emit(encI(12'h7ff, 5'd0, 3'b000, 5'd1, opImm));
        emit(encR(7'd0, 5'd1, 5'd1, 3'b000, 5'd0, opReg));
        emit(encI(12'h123, 5'd0, 3'b000, 5'd0, opImm));
        emit(encU(20'h12345, 5'd0, opLui));
        emit(encJ(21'd4, 5'd0));
        emit(encS(12'd0, 5'd0, 5'd0, 3'b011));
        expVals.push_back(64'd0);
        startProg();
        waitHalt("x0 program");
        checkStoreResults("x0", 0);
    endtask

    task automatic haltTest();
        logic [63:0] held;
        clearProg();
        emit(encI(12'd0, 5'd0, 3'b000, 5'd0, opImm));
        emit(encI(12'd0, 5'd0, 3'b000, 5'd0, opImm));
        emit(ebreakInst());
        startProg();
        waitHalt("ebreak program");
        @(negedge clk);
        held = pc;
        checkPc(held, resetPc + 64'd8);
        repeat (4) begin
            @(negedge clk);
            checkPc(pc, held);
            checkWord("halt", {63'b0, halt}, 64'd1);
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        inst = encI(12'd0, 5'd0, 3'b000, 5'd0, opImm);
        errors = 0;
        checks = 0;
        progLen = 0;
        void'($urandom(32'hc20));
        aluTest();
        memTest();
        branchTest();
        jumpTest();
        zeroRegTest();
        haltTest();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rvCore_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore_sva (
    input logic           clk,
    input logic           rstN,
    input logic [63:0]    pc,
    input rvPkg::memReq_t memReq,
    input logic           halt
);
    import rvPkg::*;

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    readNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        memReq.readEn |-> memReq.writeMask == 8'h00)
        else $error("write mask set during a load");

    haltHoldsPc: assert property (@(posedge clk) disable iff (!rstN) halt |=> $stable(pc))
        else $error("pc moved while halted");

    resetLoadsPc: assert property (@(posedge clk) $rose(rstN) |-> pc == resetPc)
        else $error("pc not at reset vector after reset");

endmodule

bind rvCore rvCore_sva u_rvCoreSva (
    .clk(clk),
    .rstN(rstN),
    .pc(pc),
    .memReq(memReq),
    .halt(halt)
);

`default_nettype wire

// File: source/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore (
    input  logic             clk,
    input  logic             rstN,
    input  rvPkg::instWord_u inst,
    input  logic [63:0]      readData,
    output logic [63:0]      pc,
    output rvPkg::memReq_t   memReq,
    output logic             halt
);
    import rvPkg::*;

    ctrl_t       ctrl;
    logic [63:0] rs1Val;
    logic [63:0] rs2Val;
    logic [63:0] imm;
    logic [63:0] aluResult;
    logic [63:0] wbData;

    assign halt = ctrl.halt;

    regFile u_regFile (
        .clk(clk),
        .rstN(rstN),
        .readAddrA(inst.rType.rs1),
        .readAddrB(inst.rType.rs2),
        .writeEn(ctrl.writeRd & ~ctrl.halt),
        .writeAddr(inst.rType.rd),
        .writeData(wbData),
        .readDataA(rs1Val),
        .readDataB(rs2Val)
    );

    instDecoder u_instDecoder (.inst(inst), .rs1Val(rs1Val), .rs2Val(rs2Val), .ctrl(ctrl));

    immGen u_immGen (.inst(inst), .imm(imm));

    aluUnit u_aluUnit (
        .ctrl(ctrl),
        .pc(pc),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .imm(imm),
        .result(aluResult)
    );

    lsuAlign u_lsuAlign (
        .ctrl(ctrl),
        .aluResult(aluResult),
        .rs2Val(rs2Val),
        .pc(pc),
        .readData(readData),
        .memReq(memReq),
        .wbData(wbData)
    );

    pcUnit u_pcUnit (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .rs1Val(rs1Val),
        .imm(imm),
        .pc(pc)
    );

endmodule

`default_nettype wire

// File: source/lsuAlign.sv
`timescale 1ns/1ps
`default_nettype none

module lsuAlign (
    input  rvPkg::ctrl_t   ctrl,
    input  logic [63:0]    aluResult,
    input  logic [63:0]    rs2Val,
    input  logic [63:0]    pc,
    input  logic [63:0]    readData,
    output rvPkg::memReq_t memReq,
    output logic [63:0]    wbData
);
    import rvPkg::*;

    logic [2:0]  offset;
    logic [63:0] shifted;
    logic [63:0] loadVal;

    assign offset = aluResult[2:0];

    assign memReq.addr = aluResult;
    assign memReq.writeData = rs2Val << {offset, 3'b000};
    assign memReq.writeMask = ctrl.storeMask << offset;
    assign memReq.readEn = ctrl.memRead;

    assign shifted = readData >> {offset, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (ctrl.loadBytes)
            4'd1:    loadVal = {{56{ctrl.loadSigned & shifted[7]}}, shifted[7:0]};
            4'd2:    loadVal = {{48{ctrl.loadSigned & shifted[15]}}, shifted[15:0]};
            4'd4:    loadVal = {{32{ctrl.loadSigned & shifted[31]}}, shifted[31:0]};
            default: loadVal = shifted;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            wbMem:   wbData = loadVal;
            wbLink:  wbData = pc + 64'd4;
            default: wbData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// File: source/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
    input  logic         clk,
    input  logic         rstN,
    input  rvPkg::ctrl_t ctrl,
    input  logic [63:0]  rs1Val,
    input  logic [63:0]  imm,
    output logic [63:0]  pc
);
    import rvPkg::*;

    logic [63:0] sum;
    logic [63:0] target;
    logic [63:0] nextPc;

    assign sum = (ctrl.baseRs1 ? rs1Val : pc) + imm;
    assign target = {sum[63:1], sum[0] & ~ctrl.baseRs1};  // jalr clears bit 0
    assign nextPc = ctrl.jump ? target : pc + 64'd4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (!ctrl.halt) begin  // hold on ebreak
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    input  logic        writeEn,
    input  logic [4:0]  writeAddr,
    input  logic [63:0] writeData,
    output logic [63:0] readDataA,
    output logic [63:0] readDataB
);

    logic [63:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin  // x0 stays zero
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

// File: source/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  rvPkg::ctrl_t ctrl,
    input  logic [63:0]  pc,
    input  logic [63:0]  rs1Val,
    input  logic [63:0]  rs2Val,
    input  logic [63:0]  imm,
    output logic [63:0]  result
);
    import rvPkg::*;

    logic [63:0] opA;
    logic [63:0] opB;
    logic [63:0] full;
    logic [31:0] word;

    assign opA = (ctrl.selA == selPc) ? pc : rs1Val;
    assign opB = (ctrl.selB == selImm) ? imm : rs2Val;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   full = opA + opB;
            aluSub:   full = opA - opB;
            aluSll:   full = opA << opB[5:0];
            aluSlt:   full = {63'b0, $signed(opA) < $signed(opB)};
            aluSltu:  full = {63'b0, opA < opB};
            aluXor:   full = opA ^ opB;
            aluSrl:   full = opA >> opB[5:0];
            aluSra:   full = $signed(opA) >>> opB[5:0];
            aluOr:    full = opA | opB;
            aluAnd:   full = opA & opB;
            aluPassB: full = opB;
            default:  full = '0;
        endcase
    end

    // word forms only use add, sub and the shifts
    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  word = opA[31:0] + opB[31:0];
            aluSub:  word = opA[31:0] - opB[31:0];
            aluSll:  word = opA[31:0] << opB[4:0];
            aluSrl:  word = opA[31:0] >> opB[4:0];
            aluSra:  word = $signed(opA[31:0]) >>> opB[4:0];
            default: word = '0;
        endcase
    end

    assign result = ctrl.aluWord ? {{32{word[31]}}, word} : full;

endmodule

`default_nettype wire

// File: source/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvPkg::instWord_u inst,
    output logic [63:0]      imm
);
    import rvPkg::*;

    always_comb begin
        case (inst.rType.opcode)
            opImm, opImmW, opLoad, opJalr: begin
                imm = {{52{inst.iType.imm12[11]}}, inst.iType.imm12};
            end
            opStore: begin
                imm = {{52{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
            end
            opBranch: begin  // imm[12|10:5] in immHi and imm[4:1|11] in immLo
                imm = {{51{inst.sType.immHi[6]}}, inst.sType.immHi[6], inst.sType.immLo[0],
                       inst.sType.immHi[5:0], inst.sType.immLo[4:1], 1'b0};
            end
            opLui, opAuipc: begin
                imm = {{32{inst.uType.imm20[19]}}, inst.uType.imm20, 12'b0};
            end
            opJal: begin  // imm[20|10:1|11|19:12]
                imm = {{43{inst.uType.imm20[19]}}, inst.uType.imm20[19],
                       inst.uType.imm20[7:0], inst.uType.imm20[8],
                       inst.uType.imm20[18:9], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input  rvPkg::instWord_u inst,
    input  logic [63:0]      rs1Val,
    input  logic [63:0]      rs2Val,
    output rvPkg::ctrl_t     ctrl
);
    import rvPkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       taken;

    assign funct3 = inst.rType.funct3;
    assign funct7 = inst.rType.funct7;

    // alt picks sub over add (reg only) and sra over srl
    function automatic aluOp_e decodeOp(input logic [2:0] f3, input logic alt,
                                        input logic isReg);
        case (f3)
            3'b000:  decodeOp = (alt && isReg) ? aluSub : aluAdd;
            3'b001:  decodeOp = aluSll;
            3'b010:  decodeOp = aluSlt;
            3'b011:  decodeOp = aluSltu;
            3'b100:  decodeOp = aluXor;
            3'b101:  decodeOp = alt ? aluSra : aluSrl;
            3'b110:  decodeOp = aluOr;
            default: decodeOp = aluAnd;
        endcase
    endfunction

    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1Val == rs2Val);
            3'b001:  taken = (rs1Val != rs2Val);
            3'b100:  taken = ($signed(rs1Val) < $signed(rs2Val));
            3'b101:  taken = ($signed(rs1Val) >= $signed(rs2Val));
            3'b110:  taken = (rs1Val < rs2Val);
            3'b111:  taken = (rs1Val >= rs2Val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluNone;
        ctrl.selA = selRs1;
        ctrl.selB = selImm;
        ctrl.wbSel = wbAlu;
        case (inst.rType.opcode)
            opReg, opImm: begin
                ctrl.writeRd = 1'b1;
                ctrl.selB = (inst.rType.opcode == opReg) ? selRs2 : selImm;
                ctrl.aluOp = decodeOp(funct3, funct7[5], inst.rType.opcode == opReg);
            end
            opRegW, opImmW: begin
                ctrl.selB = (inst.rType.opcode == opRegW) ? selRs2 : selImm;
                ctrl.aluWord = 1'b1;
                if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.writeRd = 1'b1;
                    ctrl.aluOp = decodeOp(funct3, funct7[5], inst.rType.opcode == opRegW);
                end
            end
            opLui: begin
                ctrl.writeRd = 1'b1;
                ctrl.aluOp = aluPassB;
            end
            opAuipc: begin
                ctrl.writeRd = 1'b1;
                ctrl.selA = selPc;
                ctrl.aluOp = aluAdd;
            end
            opJal: begin
                ctrl.writeRd = 1'b1;
                ctrl.wbSel = wbLink;
                ctrl.jump = 1'b1;
            end
            opJalr: begin
                ctrl.writeRd = 1'b1;
                ctrl.wbSel = wbLink;
                ctrl.jump = 1'b1;
                ctrl.baseRs1 = 1'b1;
            end
            opBranch: begin
                ctrl.jump = taken;
            end
            opLoad: begin
                if (funct3 != 3'b111) begin
                    ctrl.writeRd = 1'b1;
                    ctrl.aluOp = aluAdd;
                    ctrl.wbSel = wbMem;
                    ctrl.memRead = 1'b1;
                    ctrl.loadSigned = ~funct3[2];
                    ctrl.loadBytes = 4'd1 << funct3[1:0];
                end
            end
            opStore: begin
                ctrl.aluOp = aluAdd;
                case (funct3)
                    3'b000:  ctrl.storeMask = 8'h01;  // sb
                    3'b001:  ctrl.storeMask = 8'h03;  // sh
                    3'b010:  ctrl.storeMask = 8'h0f;  // sw
                    3'b011:  ctrl.storeMask = 8'hff;  // sd
                    default: ctrl.storeMask = 8'h00;
                endcase
            end
            opSystem: begin
                ctrl.halt = (funct3 == 3'b000) && (inst.iType.imm12 == 12'd1);  // ebreak
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int xlen = 64;
    localparam logic [xlen-1:0] resetPc = 64'h8000_0000;

    // major opcodes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opImmW   = 7'b0011011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opRegW   = 7'b0111011;
    localparam logic [6:0] opSystem = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFields_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFields_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFields_t;

    // B and J reuse the S and U bit positions
    typedef union packed {
        rFields_t rType;
        iFields_t iType;
        sFields_t sType;
        uFields_t uType;
    } instWord_u;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB, aluNone
    } aluOp_e;

    typedef enum logic { selPc, selRs1 } selA_e;
    typedef enum logic { selImm, selRs2 } selB_e;
    typedef enum logic [1:0] { wbAlu, wbMem, wbLink } wbSel_e;

    typedef struct packed {
        aluOp_e      aluOp;
        selA_e       selA;
        selB_e       selB;
        logic        aluWord;    // 32-bit op with sign-extended result
        logic        writeRd;
        wbSel_e      wbSel;
        logic        memRead;
        logic        loadSigned;
        logic [3:0]  loadBytes;  // 1, 2, 4 or 8
        logic [7:0]  storeMask;
        logic        jump;       // next pc is the target
        logic        baseRs1;    // target base is rs1
        logic        halt;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] writeData;
        logic [7:0]      writeMask;
        logic            readEn;
    } memReq_t;

endpackage

`default_nettype wire
